// ==== design/fu_defines.svh ====
////////////////////////////////////////////////////////////
// Sizing macros for the execute unit, included by the
// package and by every module that needs a width or depth
////////////////////////////////////////////////////////////
`ifndef FU_DEFINES_SVH
`define FU_DEFINES_SVH

// Datapath width
`define FU_XLEN        32

// Low bits of operand B used as shift amount
`define FU_SHAMT_W     5

// Entries in the request FIFO between select and execute
`define FU_FIFO_DEPTH  4

// Extra cycles a multiply spends in the execute stage
`define FU_MULT_CYCLES 3

`endif

// ==== design/fu_pkg.sv ====
////////////////////////////////////////////////////////////
// Operation codes and the packets passed between the
// execute pipeline stages
////////////////////////////////////////////////////////////
`include "fu_defines.svh"

package fu_pkg;

    ////////////////////////////////////////////////////////////
    // Operation and operand-source encodings
    ////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ALU_ADD    = 4'h0,
        ALU_SUB    = 4'h1,
        ALU_AND    = 4'h2,
        ALU_SLT    = 4'h3,
        ALU_SLTU   = 4'h4,
        ALU_OR     = 4'h5,
        ALU_XOR    = 4'h6,
        ALU_SRL    = 4'h7,
        ALU_SLL    = 4'h8,
        ALU_SRA    = 4'h9,
        ALU_MUL    = 4'hA,   // Low half, signed x signed
        ALU_MULH   = 4'hB,
        ALU_MULHSU = 4'hC,
        ALU_MULHU  = 4'hD
    } alu_func_e;

    typedef enum logic [1:0] {
        OPA_RS1  = 2'd0,
        OPA_NPC  = 2'd1,
        OPA_PC   = 2'd2,
        OPA_ZERO = 2'd3
    } opa_sel_e;

    // Codes 6 and 7 are unused
    typedef enum logic [2:0] {
        OPB_RS2   = 3'd0,
        OPB_I_IMM = 3'd1,
        OPB_S_IMM = 3'd2,
        OPB_B_IMM = 3'd3,
        OPB_U_IMM = 3'd4,
        OPB_J_IMM = 3'd5
    } opb_sel_e;

    ////////////////////////////////////////////////////////////
    // Stage packets
    ////////////////////////////////////////////////////////////

    // Decoded instruction as issued into the unit
    typedef struct packed {
        logic [`FU_XLEN-1:0] pc;
        logic [`FU_XLEN-1:0] npc;
        logic [`FU_XLEN-1:0] inst;
        logic [`FU_XLEN-1:0] rs1_value;
        logic [`FU_XLEN-1:0] rs2_value;
        opa_sel_e            opa_sel;
        opb_sel_e            opb_sel;
        alu_func_e           alu_func;
        logic                cond_branch;
        logic                uncond_branch;
    } fu_packet_t;

    // Operands resolved, waiting for the execute stage
    typedef struct packed {
        logic [`FU_XLEN-1:0] opa;
        logic [`FU_XLEN-1:0] opb;
        logic [`FU_XLEN-1:0] rs1_value;   // Kept for the branch compare
        logic [`FU_XLEN-1:0] rs2_value;
        logic [2:0]          funct3;
        alu_func_e           alu_func;
        logic                cond_branch;
        logic                uncond_branch;
    } exec_req_t;

    typedef struct packed {
        logic [`FU_XLEN-1:0] result;
        logic                take_branch;
    } fu_result_t;

endpackage

// ==== design/operand_select.sv ====
////////////////////////////////////////////////////////////
// Issue stage: registers a decoded packet and resolves
// operand A, operand B and the branch fields into a request
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fu_defines.svh"

module operand_select
    import fu_pkg::*;
(
    input  logic       clk_i,
    input  logic       alu_reset_i,
    input  logic       issue_valid_i,
    input  fu_packet_t issue_packet_i,
    input  logic       req_ready_i,
    output logic       issue_ready_o,
    output logic       req_valid_o,
    output exec_req_t  req_o
);

    logic [`FU_XLEN-1:0] inst;
    logic [`FU_XLEN-1:0] imm_i;
    logic [`FU_XLEN-1:0] imm_s;
    logic [`FU_XLEN-1:0] imm_b;
    logic [`FU_XLEN-1:0] imm_u;
    logic [`FU_XLEN-1:0] imm_j;
    logic [`FU_XLEN-1:0] opa_mux;
    logic [`FU_XLEN-1:0] opb_mux;
    logic                issue_fire;
    exec_req_t           req_d;

    assign inst = issue_packet_i.inst;

    ////////////////////////////////////////////////////////////
    // RV32 immediate decode, all sign-extended from bit 31
    ////////////////////////////////////////////////////////////
    assign imm_i = {{(`FU_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`FU_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`FU_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                    inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{(`FU_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};

    always_comb begin
        case (issue_packet_i.opa_sel)
            OPA_RS1: opa_mux = issue_packet_i.rs1_value;
            OPA_NPC: opa_mux = issue_packet_i.npc;
            OPA_PC:  opa_mux = issue_packet_i.pc;
            default: opa_mux = '0;   // OPA_ZERO
        endcase
    end

    always_comb begin
        case (issue_packet_i.opb_sel)
            OPB_RS2:   opb_mux = issue_packet_i.rs2_value;
            OPB_I_IMM: opb_mux = imm_i;
            OPB_S_IMM: opb_mux = imm_s;
            OPB_B_IMM: opb_mux = imm_b;
            OPB_U_IMM: opb_mux = imm_u;
            OPB_J_IMM: opb_mux = imm_j;
            default:   opb_mux = '0;
        endcase
    end

    always_comb begin
        req_d.opa           = opa_mux;
        req_d.opb           = opb_mux;
        req_d.rs1_value     = issue_packet_i.rs1_value;
        req_d.rs2_value     = issue_packet_i.rs2_value;
        req_d.funct3        = inst[14:12];
        req_d.alu_func      = issue_packet_i.alu_func;
        req_d.cond_branch   = issue_packet_i.cond_branch;
        req_d.uncond_branch = issue_packet_i.uncond_branch;
    end

    ////////////////////////////////////////////////////////////
    // Single output slot
    ////////////////////////////////////////////////////////////
    assign issue_ready_o = !req_valid_o || req_ready_i;   // Empty or draining
    assign issue_fire    = issue_valid_i && issue_ready_o;

    always_ff @(posedge clk_i) begin
        if (alu_reset_i) begin
            req_valid_o <= 1'b0;
        end else if (issue_fire) begin
            req_valid_o <= 1'b1;
        end else if (req_ready_i) begin
            req_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_fire) begin
            req_o <= req_d;
        end
    end

    // Upstream decoder must only offer defined operand B sources
    a_opb_sel_legal: assert property (@(posedge clk_i) disable iff (alu_reset_i)
        issue_valid_i |-> issue_packet_i.opb_sel inside
            {OPB_RS2, OPB_I_IMM, OPB_S_IMM, OPB_B_IMM, OPB_U_IMM, OPB_J_IMM});

endmodule

// ==== design/fu_fifo.sv ====
////////////////////////////////////////////////////////////
// Synchronous FIFO for any packed payload, valid/ready on
// both sides; a write shows at the head the next cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fu_defines.svh"

module fu_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     alu_reset_i,
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    input  logic     out_ready_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output payload_t out_data_o
);

    localparam int DEPTH = `FU_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Wraps at DEPTH, so the depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready_o  = (count != CNT_W'(DEPTH));
    assign out_valid_o = (count != '0);
    assign out_data_o  = mem[rd_ptr];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (alu_reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Idle or push and pop together
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
    end

    a_count_bound: assert property (@(posedge clk_i) disable iff (alu_reset_i)
        count <= CNT_W'(DEPTH));

    // Read side only moves after a cycle in which something was stored
    a_no_empty_pop: assert property (@(posedge clk_i) disable iff (alu_reset_i)
        (rd_ptr != $past(rd_ptr)) |-> ($past(count) != '0));

endmodule

// ==== design/exec_unit.sv ====
////////////////////////////////////////////////////////////
// Execute stage: ALU, multiplier and branch compare; holds
// multiplies for a fixed wait and keeps results until taken
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fu_defines.svh"

module exec_unit
    import fu_pkg::*;
(
    input  logic       clk_i,
    input  logic       alu_reset_i,
    input  logic       req_valid_i,
    input  exec_req_t  req_i,
    input  logic       res_ready_i,
    output logic       req_ready_o,
    output logic       res_valid_o,
    output fu_result_t res_o
);

    localparam int CNT_W = $clog2(`FU_MULT_CYCLES + 1);

    exec_req_t              req_q;      // Multiply waiting out its latency
    exec_req_t              cur;
    logic                   busy;
    logic [CNT_W-1:0]       wait_cnt;
    logic                   accept;
    logic                   cur_is_mult;
    logic                   mult_done;
    logic                   load_res;
    logic [`FU_SHAMT_W-1:0] shamt;
    logic [2*`FU_XLEN-1:0]  opa_sx;
    logic [2*`FU_XLEN-1:0]  opb_sx;
    logic [2*`FU_XLEN-1:0]  opa_zx;
    logic [2*`FU_XLEN-1:0]  opb_zx;
    logic [2*`FU_XLEN-1:0]  prod_ss;
    logic [2*`FU_XLEN-1:0]  prod_su;
    logic [2*`FU_XLEN-1:0]  prod_uu;
    logic                   br_cond;
    fu_result_t             res_d;

    // ALU ops finish at accept, so compute straight off the input then
    assign cur         = busy ? req_q : req_i;
    assign cur_is_mult = cur.alu_func inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};
    assign shamt       = cur.opb[`FU_SHAMT_W-1:0];

    ////////////////////////////////////////////////////////////
    // Multiplier, products taken modulo 2*XLEN
    ////////////////////////////////////////////////////////////
    assign opa_sx  = {{`FU_XLEN{cur.opa[`FU_XLEN-1]}}, cur.opa};
    assign opb_sx  = {{`FU_XLEN{cur.opb[`FU_XLEN-1]}}, cur.opb};
    assign opa_zx  = {{`FU_XLEN{1'b0}}, cur.opa};
    assign opb_zx  = {{`FU_XLEN{1'b0}}, cur.opb};
    assign prod_ss = opa_sx * opb_sx;
    assign prod_su = opa_sx * opb_zx;
    assign prod_uu = opa_zx * opb_zx;

    always_comb begin
        case (cur.alu_func)
            ALU_ADD:    res_d.result = cur.opa + cur.opb;
            ALU_SUB:    res_d.result = cur.opa - cur.opb;
            ALU_AND:    res_d.result = cur.opa & cur.opb;
            ALU_SLT:    res_d.result = {{(`FU_XLEN-1){1'b0}}, $signed(cur.opa) < $signed(cur.opb)};
            ALU_SLTU:   res_d.result = {{(`FU_XLEN-1){1'b0}}, cur.opa < cur.opb};
            ALU_OR:     res_d.result = cur.opa | cur.opb;
            ALU_XOR:    res_d.result = cur.opa ^ cur.opb;
            ALU_SRL:    res_d.result = cur.opa >> shamt;
            ALU_SLL:    res_d.result = cur.opa << shamt;
            ALU_SRA:    res_d.result = $signed(cur.opa) >>> shamt;
            ALU_MUL:    res_d.result = prod_ss[`FU_XLEN-1:0];
            ALU_MULH:   res_d.result = prod_ss[2*`FU_XLEN-1:`FU_XLEN];
            ALU_MULHSU: res_d.result = prod_su[2*`FU_XLEN-1:`FU_XLEN];
            ALU_MULHU:  res_d.result = prod_uu[2*`FU_XLEN-1:`FU_XLEN];
            default:    res_d.result = '0;
        endcase
    end

    // Branch compare on the raw register values
    always_comb begin
        case (cur.funct3)
            3'b000:  br_cond = (cur.rs1_value == cur.rs2_value);                   // BEQ
            3'b001:  br_cond = (cur.rs1_value != cur.rs2_value);                   // BNE
            3'b100:  br_cond = ($signed(cur.rs1_value) < $signed(cur.rs2_value));  // BLT
            3'b101:  br_cond = ($signed(cur.rs1_value) >= $signed(cur.rs2_value)); // BGE
            3'b110:  br_cond = (cur.rs1_value < cur.rs2_value);                    // BLTU
            3'b111:  br_cond = (cur.rs1_value >= cur.rs2_value);                   // BGEU
            default: br_cond = 1'b0;
        endcase
    end

    assign res_d.take_branch = cur.uncond_branch || (cur.cond_branch && br_cond);

    ////////////////////////////////////////////////////////////
    // Control: accept, multiply wait, result slot
    ////////////////////////////////////////////////////////////
    assign req_ready_o = !busy && (!res_valid_o || res_ready_i);
    assign accept      = req_valid_i && req_ready_o;
    assign mult_done   = busy && (wait_cnt == '0);
    assign load_res    = (accept && !cur_is_mult) || mult_done;

    always_ff @(posedge clk_i) begin
        if (alu_reset_i) begin
            busy        <= 1'b0;
            wait_cnt    <= '0;
            res_valid_o <= 1'b0;
        end else begin
            if (res_valid_o && res_ready_i) begin
                res_valid_o <= 1'b0;
            end
            if (accept && cur_is_mult) begin
                busy     <= 1'b1;
                wait_cnt <= CNT_W'(`FU_MULT_CYCLES - 1);
            end else if (mult_done) begin
                busy <= 1'b0;
            end else if (busy) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
            // Slot was emptied at accept, so a finishing multiply never collides
            if (load_res) begin
                res_valid_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && cur_is_mult) begin
            req_q <= req_i;
        end
        if (load_res) begin
            res_o <= res_d;
        end
    end

    // A stalled result must be held intact for the receiver
    a_res_stable: assert property (@(posedge clk_i) disable iff (alu_reset_i)
        (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o)));

endmodule

// ==== design/fu_top.sv ====
////////////////////////////////////////////////////////////
// Execute unit top: operand select, request FIFO and
// execute stage chained with valid/ready links
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fu_top
    import fu_pkg::*;
(
    input  logic       clk_i,
    input  logic       alu_reset_i,
    input  logic       issue_valid_i,
    input  fu_packet_t issue_packet_i,
    input  logic       res_ready_i,
    output logic       issue_ready_o,
    output logic       res_valid_o,
    output fu_result_t res_o
);

    logic      req_valid;   // Select stage to FIFO
    logic      req_ready;
    exec_req_t req;
    logic      head_valid;  // FIFO to execute stage
    logic      head_ready;
    exec_req_t head;

    operand_select u_operand_select (
        .clk_i          (clk_i),
        .alu_reset_i    (alu_reset_i),
        .issue_valid_i  (issue_valid_i),
        .issue_packet_i (issue_packet_i),
        .req_ready_i    (req_ready),
        .issue_ready_o  (issue_ready_o),
        .req_valid_o    (req_valid),
        .req_o          (req)
    );

    fu_fifo #(
        .payload_t (exec_req_t)
    ) u_fu_fifo (
        .clk_i       (clk_i),
        .alu_reset_i (alu_reset_i),
        .in_valid_i  (req_valid),
        .in_data_i   (req),
        .out_ready_i (head_ready),
        .in_ready_o  (req_ready),
        .out_valid_o (head_valid),
        .out_data_o  (head)
    );

    exec_unit u_exec_unit (
        .clk_i       (clk_i),
        .alu_reset_i (alu_reset_i),
        .req_valid_i (head_valid),
        .req_i       (head),
        .res_ready_i (res_ready_i),
        .req_ready_o (head_ready),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

endmodule

// ==== test/fu_model.svh ====
////////////////////////////////////////////////////////////
// Reference model and compare tasks, included in the body
// of the testbench top module
////////////////////////////////////////////////////////////
`ifndef FU_MODEL_SVH
`define FU_MODEL_SVH

// Operand B as the instruction format defines it
function automatic logic [`FU_XLEN-1:0] model_opb(input fu_packet_t p);
    logic [31:0] in;
    in = p.inst;
    case (p.opb_sel)
        OPB_RS2:   return p.rs2_value;
        OPB_I_IMM: return 32'($signed(in[31:20]));
        OPB_S_IMM: return 32'($signed({in[31:25], in[11:7]}));
        OPB_B_IMM: return 32'($signed({in[31], in[7], in[30:25], in[11:8], 1'b0}));
        OPB_U_IMM: return {in[31:12], 12'h000};
        default:   return 32'($signed({in[31], in[19:12], in[20], in[30:21], 1'b0}));
    endcase
endfunction

function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return !($signed(a) < $signed(b));
        3'd6:    return a < b;
        3'd7:    return !(a < b);
        default: return 1'b0;   // Codes 2 and 3 are not branches
    endcase
endfunction

function automatic fu_result_t model_result(input fu_packet_t p);
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] prod;
    fu_result_t  r;
    a = (p.opa_sel == OPA_RS1) ? p.rs1_value : (p.opa_sel == OPA_NPC) ? p.npc :
        (p.opa_sel == OPA_PC) ? p.pc : 32'h0;
    b = model_opb(p);
    case (p.alu_func)
        ALU_ADD:  r.result = a + b;
        ALU_SUB:  r.result = a + ~b + 32'd1;
        ALU_AND:  r.result = a & b;
        ALU_SLT:  r.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        ALU_SLTU: r.result = (a < b) ? 32'd1 : 32'd0;
        ALU_OR:   r.result = a | b;
        ALU_XOR:  r.result = a ^ b;
        ALU_SRL:  r.result = a >> b[`FU_SHAMT_W-1:0];
        ALU_SLL:  r.result = a << b[`FU_SHAMT_W-1:0];
        ALU_SRA:  r.result = 32'($signed(a) >>> b[`FU_SHAMT_W-1:0]);
        ALU_MUL, ALU_MULH: begin
            prod = longint'($signed(a)) * longint'($signed(b));
            r.result = (p.alu_func == ALU_MUL) ? prod[31:0] : prod[63:32];
        end
        ALU_MULHSU: begin
            prod = longint'($signed(a)) * longint'({32'h0, b});
            r.result = prod[63:32];
        end
        default: begin   // MULHU
            prod = {32'h0, a} * {32'h0, b};
            r.result = prod[63:32];
        end
    endcase
    r.take_branch = p.uncond_branch || (p.cond_branch && branch_cond(p.inst[14:12],
                    p.rs1_value, p.rs2_value));
    return r;
endfunction

task automatic check_result(input string name, input fu_result_t exp, input fu_result_t act);
    if (exp !== act) begin
        $display("FAIL %s: expected result=%h take_branch=%h, got result=%h take_branch=%h",
                 name, exp.result, exp.take_branch, act.result, act.take_branch);
        stop_run();
    end
endtask

task automatic check_idle(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        $display("FAIL %s: expected %h, got %h", name, exp, act);
        stop_run();
    end
endtask

`endif

// ==== test/fu_tb.sv ====
////////////////////////////////////////////////////////////
// Random-stimulus testbench for the execute unit; results
// are checked in issue order against the reference model
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fu_defines.svh"

module fu_tb
    import fu_pkg::*;
();

    localparam int NUM_PKTS       = 400;
    localparam int TIMEOUT_CYCLES = NUM_PKTS * (`FU_MULT_CYCLES + 4) * 4;

    logic        clk_i;
    logic        alu_reset_i;
    logic        issue_valid_i;
    fu_packet_t  issue_packet_i;
    logic        res_ready_i;
    logic        issue_ready_o;
    logic        res_valid_o;
    fu_result_t  res_o;

    int          seed;
    int unsigned cycles;
    int          n_done;
    fu_result_t  exp_q[$];      // Scoreboard in issue order
    fu_result_t  res_prev;
    logic        stall_prev;
    fu_packet_t  pkt;

    fu_top DUT (
        .clk_i          (clk_i),
        .alu_reset_i    (alu_reset_i),
        .issue_valid_i  (issue_valid_i),
        .issue_packet_i (issue_packet_i),
        .res_ready_i    (res_ready_i),
        .issue_ready_o  (issue_ready_o),
        .res_valid_o    (res_valid_o),
        .res_o          (res_o)
    );

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    `include "fu_model.svh"

    task automatic make_packet(output fu_packet_t p);
        int kind;
        kind            = $random(seed) & 7;
        p.pc            = $random(seed);
        p.npc           = p.pc + 32'd4;
        p.inst          = $random(seed);
        p.rs1_value     = $random(seed);
        p.rs2_value     = $random(seed);
        p.opa_sel       = opa_sel_e'($random(seed) & 3);
        p.opb_sel       = opb_sel_e'(unsigned'($random(seed)) % 6);
        p.alu_func      = alu_func_e'(unsigned'($random(seed)) % 14);
        p.cond_branch   = (kind == 0);
        p.uncond_branch = (kind == 1);
        if (kind < 2) begin   // Target add for branches
            p.alu_func = ALU_ADD;
            p.opa_sel  = OPA_PC;
            p.opb_sel  = (kind == 0) ? OPB_B_IMM : OPB_J_IMM;
            if ($random(seed) & 1) begin
                p.rs2_value = p.rs1_value;
            end
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        seed           = 35511;
        alu_reset_i    = 1'b1;
        issue_valid_i  = 1'b0;
        issue_packet_i = '0;
        res_ready_i    = 1'b0;
        repeat (10) @(posedge clk_i);
        #1 alu_reset_i = 1'b0;
        @(negedge clk_i);
        check_idle("issue_ready_o", 1'b1, issue_ready_o);
        check_idle("res_valid_o", 1'b0, res_valid_o);
        @(posedge clk_i);
        #1;
        repeat (NUM_PKTS) begin
            make_packet(pkt);
            issue_valid_i  = 1'b1;
            issue_packet_i = pkt;
            do begin
                @(negedge clk_i);
            end while (!issue_ready_o);
            exp_q.push_back(model_result(pkt));   // Transfer on the coming edge
            @(posedge clk_i);
            #1;
        end
        issue_valid_i = 1'b0;
        wait (n_done == NUM_PKTS);
        repeat (20) @(posedge clk_i);   // Room for any stray extra result
        if (exp_q.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("Expected results still queued at the end of the run");
            stop_run();
        end
    end

    // Random back-pressure, about half the cycles
    always @(posedge clk_i) begin
        #1 res_ready_i = $random(seed) & 1;
    end

    ////////////////////////////////////////////////////////////
    // Result monitor, sampled mid-cycle
    ////////////////////////////////////////////////////////////
    always @(negedge clk_i) begin
        if (alu_reset_i) begin
            stall_prev = 1'b0;
        end else begin
            if (stall_prev) begin
                check_idle("res_valid_o (stalled)", 1'b1, res_valid_o);
                check_result("res_o (stalled)", res_prev, res_o);
            end
            if (res_valid_o && res_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("A result came out with no packet outstanding");
                    stop_run();
                end else begin
                    check_result("res_o", exp_q.pop_front(), res_o);
                    n_done++;
                end
            end
            stall_prev = res_valid_o && !res_ready_i;
            res_prev   = res_o;
        end
    end

    initial cycles = 0;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the pipeline hung before all results came out");
            stop_run();
        end
    end

endmodule

// ==== fu_top.f ====
+incdir+design
+incdir+test
design/fu_pkg.sv
design/operand_select.sv
design/fu_fifo.sv
design/exec_unit.sv
design/fu_top.sv
test/fu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the execute unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module fu_tb -f fu_top.f -o fu_sim

# A fatal stop exits non-zero, so keep the output and judge by its contents
out=$(./obj_dir/fu_sim 2>&1) || true
echo "$out"

if grep -qx "TESTS PASSED" <<< "$out"; then
    exit 0
else
    exit 1
fi
